/* logic/mem_pkg.sv */
package mem_pkg;

	localparam int LANES = 8;
	localparam int LANE_W = 32;

	localparam int LOCAL_WORDS = 256;
	localparam int SHARED_WORDS = 256;
	localparam int ADDR_W = $clog2(LOCAL_WORDS + SHARED_WORDS); // local and shared share one space.

	localparam int MISS_DEPTH = 8;
	localparam int ADDR_FULL_W = 27;

	// lane 0 sits in the low word of a line.
	typedef logic [LANES-1:0][LANE_W-1:0] line_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] addr;
		line_t line;
	} fill_t;

endpackage

/* logic/gpu_pkg.sv */
package gpu_pkg;

	localparam int WARP_W = 3;
	localparam int SCB_W = 2;
	localparam int REG_W = 5;
	localparam int THREADS = 8;
	localparam int OFFSET_W = 24;
	localparam int LAT_W = 5; // miss latency field.

	typedef struct packed {
		logic [WARP_W-1:0] warp_id;
		logic [SCB_W-1:0] scb_id;
		logic [REG_W-1:0] reg_addr;
		logic [THREADS-1:0] thread_mask;
		logic [OFFSET_W-1:0] word_offset;
	} warp_tag_t;

	typedef struct packed {
		logic read;
		logic write;
		logic [mem_pkg::LANES-1:0] write_mask;
		logic [mem_pkg::ADDR_FULL_W-1:0] addr;
		mem_pkg::line_t data;
		warp_tag_t tag;
	} mem_req_t;

	typedef struct packed {
		logic reg_write;
		logic store_done;
		warp_tag_t tag;
		mem_pkg::line_t data;
	} wb_t;

	typedef struct packed {
		logic valid;
		logic [mem_pkg::ADDR_FULL_W-1:0] addr;
		logic [WARP_W-1:0] warp_id;
		logic [SCB_W-1:0] scb_id;
		logic [LAT_W-1:0] latency;
	} miss_req_t;

	typedef struct packed {
		logic valid;
		logic [mem_pkg::ADDR_FULL_W-1:0] addr;
		logic [WARP_W-1:0] warp_id;
		logic [SCB_W-1:0] scb_id;
	} neg_fb_t;

endpackage

/* logic/mem_request_decode.sv */
`timescale 1ns/1ps

module mem_request_decode
(
	input logic clk,
	input logic resetb,
	input gpu_pkg::mem_req_t req_i,
	input mem_pkg::fill_t fill_i,
	output logic [mem_pkg::LANES-1:0] lane_we_o,
	output logic [mem_pkg::ADDR_W-1:0] wr_addr_o,
	output logic [mem_pkg::ADDR_W-1:0] rd_addr_o,
	output mem_pkg::line_t wr_line_o,
	output logic rd_pend_o,
	output logic st_pend_o,
	output gpu_pkg::warp_tag_t tag_o
);
	import mem_pkg::*;

	logic [LANES-1:0] st_we;

	assign st_we = req_i.write ? req_i.write_mask : '0;

	// a fill owns the write port and drops any store lanes.
	assign lane_we_o = fill_i.valid ? {LANES{1'b1}} : st_we;
	assign wr_addr_o = fill_i.valid ? fill_i.addr : req_i.addr[ADDR_W-1:0];
	assign wr_line_o = fill_i.valid ? fill_i.line : req_i.data;

	assign rd_addr_o = req_i.addr[ADDR_W-1:0]; // upper address bits wrap.

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			rd_pend_o <= 1'b0;
			st_pend_o <= 1'b0;
		end
		else
		begin
			rd_pend_o <= req_i.read;
			st_pend_o <= req_i.write; // completion is reported even when a fill took the port.
		end
	end

	always_ff @(posedge clk)
	begin
		tag_o <= req_i.tag;
	end

endmodule

/* logic/lane_bram.sv */
`timescale 1ns/1ps

module lane_bram
#(
	parameter int DEPTH = mem_pkg::LOCAL_WORDS + mem_pkg::SHARED_WORDS,
	localparam int AW = $clog2(DEPTH)
)
(
	input logic clk,
	input logic we_i,
	input logic [AW-1:0] wr_addr_i,
	input logic [mem_pkg::LANE_W-1:0] wr_data_i,
	input logic [AW-1:0] rd_addr_i,
	output logic [mem_pkg::LANE_W-1:0] rd_data_o
);
	import mem_pkg::*;

	logic [LANE_W-1:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		rd_data_o <= mem[rd_addr_i]; // old contents win on a same-address write.
		if (we_i)
		begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

endmodule

/* logic/miss_tracker.sv */
`timescale 1ns/1ps

module miss_tracker
(
	input logic clk,
	input logic resetb,
	input gpu_pkg::miss_req_t miss_i,
	input logic miss_wait_i,
	output gpu_pkg::neg_fb_t neg_fb_o,
	output logic full_o
);
	import gpu_pkg::*;
	import mem_pkg::*;

	localparam int PTR_W = $clog2(MISS_DEPTH);

	logic [ADDR_FULL_W-1:0] ent_addr [MISS_DEPTH];
	logic [WARP_W-1:0] ent_warp [MISS_DEPTH];
	logic [SCB_W-1:0] ent_scb [MISS_DEPTH];
	logic [LAT_W-1:0] ent_cnt [MISS_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] occupancy;
	logic [LAT_W-1:0] lat_in;
	logic push;
	logic pop;

	logic fb_valid_q;
	logic [ADDR_FULL_W-1:0] fb_addr_q;
	logic [WARP_W-1:0] fb_warp_q;
	logic [SCB_W-1:0] fb_scb_q;

	assign full_o = (occupancy == (PTR_W + 1)'(MISS_DEPTH));

	// a zero latency still costs one cycle.
	assign lat_in = (miss_wait_i || miss_i.latency == '0) ? LAT_W'(1) : miss_i.latency;

	assign push = miss_i.valid && !full_o; // misses offered while full are lost.
	assign pop = (occupancy != '0) && (ent_cnt[rd_ptr] == '0);

	// every entry counts down on its own, so a finished entry may still wait behind a slow head.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < MISS_DEPTH; i++)
		begin
			if (ent_cnt[i] != '0)
			begin
				ent_cnt[i] <= ent_cnt[i] - 1'b1;
			end
		end
		if (push)
		begin
			ent_addr[wr_ptr] <= miss_i.addr;
			ent_warp[wr_ptr] <= miss_i.warp_id;
			ent_scb[wr_ptr] <= miss_i.scb_id;
			ent_cnt[wr_ptr] <= lat_in;
		end
	end

	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
			fb_valid_q <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
			fb_valid_q <= pop;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			fb_addr_q <= ent_addr[rd_ptr];
			fb_warp_q <= ent_warp[rd_ptr];
			fb_scb_q <= ent_scb[rd_ptr];
		end
	end

	assign neg_fb_o = neg_fb_t'{valid: fb_valid_q, addr: fb_addr_q,
		warp_id: fb_warp_q, scb_id: fb_scb_q};

endmodule

/* logic/mem_writeback.sv */
`timescale 1ns/1ps

module mem_writeback
(
	input logic clk,
	input logic resetb,
	input logic rd_pend_i,
	input logic st_pend_i,
	input gpu_pkg::warp_tag_t tag_i,
	input mem_pkg::line_t rd_line_i,
	output gpu_pkg::wb_t wb_o
);
	import gpu_pkg::*;

	wb_t wb_d;

	always_comb
	begin
		wb_d.reg_write = rd_pend_i;
		wb_d.store_done = st_pend_i;
		wb_d.tag = tag_i;
		wb_d.data = rd_pend_i ? rd_line_i : '0; // register file sees zeros unless it is a load.
	end

	// data is cleared as well, so it reads zero from reset onward.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
		begin
			wb_o <= '0;
		end
		else
		begin
			wb_o <= wb_d;
		end
	end

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage
(
	input logic clk,
	input logic resetb,
	input gpu_pkg::mem_req_t req_i,
	input mem_pkg::fill_t fill_i,
	input gpu_pkg::miss_req_t miss_i,
	input logic miss_wait_i,
	output gpu_pkg::wb_t wb_o,
	output gpu_pkg::neg_fb_t neg_fb_o,
	output logic miss_full_o
);
	import gpu_pkg::*;
	import mem_pkg::*;

	logic [LANES-1:0] lane_we;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	line_t wr_line;
	line_t rd_line;
	logic rd_pend;
	logic st_pend;
	warp_tag_t tag;

	mem_request_decode u_decode
	(
		.clk(clk),
		.resetb(resetb),
		.req_i(req_i),
		.fill_i(fill_i),
		.lane_we_o(lane_we),
		.wr_addr_o(wr_addr),
		.rd_addr_o(rd_addr),
		.wr_line_o(wr_line),
		.rd_pend_o(rd_pend),
		.st_pend_o(st_pend),
		.tag_o(tag)
	);

	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		lane_bram #(.DEPTH(LOCAL_WORDS + SHARED_WORDS)) u_lane
		(
			.clk(clk),
			.we_i(lane_we[i]),
			.wr_addr_i(wr_addr),
			.wr_data_i(wr_line[i]),
			.rd_addr_i(rd_addr),
			.rd_data_o(rd_line[i])
		);
	end

	miss_tracker u_miss_tracker
	(
		.clk(clk),
		.resetb(resetb),
		.miss_i(miss_i),
		.miss_wait_i(miss_wait_i),
		.neg_fb_o(neg_fb_o),
		.full_o(miss_full_o)
	);

	mem_writeback u_writeback
	(
		.clk(clk),
		.resetb(resetb),
		.rd_pend_i(rd_pend),
		.st_pend_i(st_pend),
		.tag_i(tag),
		.rd_line_i(rd_line),
		.wb_o(wb_o)
	);

endmodule

/* verification/mem_stage_checker.sv */
`timescale 1ns/1ps

module mem_stage_checker
(
	input logic clk,
	input logic resetb,
	input gpu_pkg::miss_req_t miss_i,
	input logic miss_full_i,
	input gpu_pkg::wb_t wb_i,
	input gpu_pkg::neg_fb_t neg_fb_i
);
	import gpu_pkg::*;
	import mem_pkg::*;

	localparam int PW = $clog2(MISS_DEPTH) + 1;

	logic [PW-1:0] pending;
	logic push;

	assign push = miss_i.valid && !miss_full_i;

	// misses accepted but not yet returned.
	always_ff @(posedge clk or negedge resetb)
	begin
		if (!resetb)
			pending <= '0;
		else
			pending <= pending + PW'(push) - PW'(neg_fb_i.valid);
	end

	a_reset_quiet: assert property (@(posedge clk)
		!resetb |-> !wb_i.reg_write && !wb_i.store_done)
		else $error("writeback strobe seen during reset");

	a_data_zero: assert property (@(posedge clk) disable iff (!resetb)
		!wb_i.reg_write |-> wb_i.data == '0)
		else $error("writeback data not zero without reg_write");

	a_fb_needs_entry: assert property (@(posedge clk) disable iff (!resetb)
		neg_fb_i.valid |-> pending != '0)
		else $error("negative feedback from an empty miss tracker");

endmodule

bind mem_stage mem_stage_checker u_checker
(
	.clk(clk),
	.resetb(resetb),
	.miss_i(miss_i),
	.miss_full_i(miss_full_o),
	.wb_i(wb_o),
	.neg_fb_i(neg_fb_o)
);

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ps

module mem_stage_tb;
	import gpu_pkg::*;
	import mem_pkg::*;

	localparam int LINES = LOCAL_WORDS + SHARED_WORDS;
	localparam int RAND_CYCLES = 800;
	localparam int MAX_LAT = 31;
	localparam int DRAIN_CYCLES = MAX_LAT * MISS_DEPTH + 16;
	localparam int TIMEOUT = 4 + LINES + 1 + RAND_CYCLES + DRAIN_CYCLES + 64;
	localparam int TAG_W = $bits(warp_tag_t);
	localparam int MISS_W = $bits(miss_req_t);

	logic clk;
	logic resetb;
	mem_req_t req;
	fill_t fill;
	miss_req_t miss;
	logic miss_wait;
	wb_t wb;
	neg_fb_t neg_fb;
	logic miss_full;

	line_t model_mem [LINES];
	wb_t wb_exp [$];
	int wb_due [$];
	neg_fb_t fb_exp [$];
	int fb_entry [$];
	int fb_lat [$];
	int cycle;
	logic full_seen;
	string test_name;
	int unsigned seed_val;

	mem_stage DUT
	(
		.clk(clk),
		.resetb(resetb),
		.req_i(req),
		.fill_i(fill),
		.miss_i(miss),
		.miss_wait_i(miss_wait),
		.wb_o(wb),
		.neg_fb_o(neg_fb),
		.miss_full_o(miss_full)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle > TIMEOUT)
		begin
			$display("timeout: the run went past its cycle limit without finishing");
			stop_with_failure();
		end
	end

	task automatic stop_with_failure();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_wb(input string name, input wb_t exp, input wb_t act);
		if (act.reg_write !== exp.reg_write || act.store_done !== exp.store_done ||
			act.data !== exp.data || ((exp.reg_write || exp.store_done) && act.tag !== exp.tag))
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_fb(input string name, input neg_fb_t exp, input neg_fb_t act);
		if (act.valid !== exp.valid || (exp.valid && act !== exp))
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			stop_with_failure();
		end
	endtask

	function automatic line_t rand_line();
		line_t l;
		for (int i = 0; i < LANES; i++)
			l[i] = $urandom();
		return l;
	endfunction

	// the model reads before it writes, like the lane RAMs.
	task automatic apply(input mem_req_t r, input fill_t f, input miss_req_t m, input logic w);
		logic [ADDR_W-1:0] idx;
		wb_t e;
		idx = ADDR_W'(int'(r.addr) % LINES);
		e.reg_write = r.read;
		e.store_done = r.write;
		e.tag = r.tag;
		e.data = r.read ? model_mem[idx] : '0;
		wb_exp.push_back(e);
		wb_due.push_back(cycle + 2);
		if (f.valid)
			model_mem[f.addr] = f.line;
		else if (r.write)
		begin
			for (int l = 0; l < LANES; l++)
				if (r.write_mask[l])
					model_mem[idx][l] = r.data[l];
		end
		if (m.valid)
		begin
			fb_exp.push_back(neg_fb_t'{valid: 1'b1, addr: m.addr, warp_id: m.warp_id,
				scb_id: m.scb_id});
			fb_entry.push_back(cycle + 1);
			fb_lat.push_back((w || m.latency == '0) ? 1 : int'(m.latency));
		end
		req = r;
		fill = f;
		miss = m;
		miss_wait = w;
	endtask

	task automatic next_cycle();
		neg_fb_t e;
		int entered;
		int lat;
		@(posedge clk);
		#1;
		if (wb_due.size() > 0 && wb_due[0] == cycle)
		begin
			void'(wb_due.pop_front());
			check_wb(test_name, wb_exp.pop_front(), wb);
		end
		if (neg_fb.valid && fb_exp.size() == 0)
		begin
			$display("negative feedback arrived while no miss was outstanding");
			stop_with_failure();
		end
		else if (neg_fb.valid)
		begin
			e = fb_exp.pop_front();
			entered = fb_entry.pop_front();
			lat = fb_lat.pop_front();
			check_fb(test_name, e, neg_fb);
			if (cycle - entered < lat)
			begin
				$display("[ERROR] %s: feedback delay expected at least %0d, actual %0d",
					test_name, lat, cycle - entered);
				stop_with_failure();
			end
		end
		else
			check_fb(test_name, neg_fb_t'('0), neg_fb);
		check_bit(test_name, fb_exp.size() == MISS_DEPTH, miss_full);
		if (miss_full)
			full_seen = 1'b1;
	endtask

	initial
	begin
		mem_req_t r;
		fill_t f;
		miss_req_t m;
		logic w;
		seed_val = $urandom(7);
		clk = 1'b0;
		resetb = 1'b0;
		req = '0;
		fill = '0;
		miss = '0;
		miss_wait = 1'b0;
		full_seen = 1'b0;
		repeat (2) @(posedge clk);
		#1 resetb = 1'b1;
		test_name = "reset_idle";
		repeat (4)
		begin
			next_cycle();
			check_wb(test_name, wb_t'('0), wb);
		end
		// every line gets filled once, and each fill is read back on the next cycle.
		test_name = "fill_then_load";
		for (int i = 0; i <= LINES; i++)
		begin
			r = '0;
			f = '0;
			m = '0;
			if (i < LINES)
				f = fill_t'{valid: 1'b1, addr: ADDR_W'(i), line: rand_line()};
			if (i > 0)
			begin
				r.read = 1'b1;
				r.addr = ADDR_FULL_W'($urandom()); // upper bits must wrap.
				r.addr[ADDR_W-1:0] = ADDR_W'(i - 1);
				r.tag = TAG_W'({$urandom(), $urandom()});
			end
			apply(r, f, m, 1'b0);
			next_cycle();
		end
		test_name = "random_mix";
		repeat (RAND_CYCLES)
		begin
			r = '0;
			f = '0;
			m = '0;
			r.read = $urandom_range(0, 3) < 2;
			r.write = $urandom_range(0, 3) < 2;
			r.write_mask = LANES'($urandom());
			r.addr = ADDR_FULL_W'($urandom());
			if ($urandom_range(0, 1) == 1)
				r.addr[ADDR_W-1:0] = ADDR_W'($urandom_range(0, 15)); // hot lines get reread.
			r.data = rand_line();
			r.tag = TAG_W'({$urandom(), $urandom()});
			f.valid = $urandom_range(0, 5) == 0;
			f.addr = ($urandom_range(0, 1) == 1) ? r.addr[ADDR_W-1:0] : ADDR_W'($urandom());
			f.line = rand_line();
			if (!miss_full && $urandom_range(0, 1) == 1)
			begin
				m = MISS_W'({$urandom(), $urandom()});
				m.valid = 1'b1;
			end
			w = $urandom_range(0, 7) == 0;
			apply(r, f, m, w);
			next_cycle();
		end
		test_name = "drain";
		repeat (DRAIN_CYCLES)
		begin
			apply(mem_req_t'('0), fill_t'('0), miss_req_t'('0), 1'b0);
			next_cycle();
		end
		repeat (2) next_cycle();
		if (fb_exp.size() == 0 && wb_exp.size() == 0 && full_seen)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("results were still outstanding or the miss tracker never filled up");
			stop_with_failure();
		end
	end

endmodule

/* filelist.f */
logic/mem_pkg.sv
logic/gpu_pkg.sv
logic/mem_request_decode.sv
logic/lane_bram.sv
logic/miss_tracker.sv
logic/mem_writeback.sv
logic/mem_stage.sv
verification/mem_stage_checker.sv
verification/mem_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = mem_stage_tb
FILELIST = filelist.f
OBJ_DIR = obj_dir
PASS_MSG = test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
